/* flist.f */
+incdir+include
verilog/lpc_pkg.sv
verilog/fix_divider.sv
verilog/ld_sequencer.sv
verilog/coef_lane.sv
verilog/lpc_drain.sv
verilog/levinson_durbin.sv
bench/tb_levinson_durbin.sv

/* Makefile */
# Verilator build for the Levinson-Durbin recursion

VERILATOR  = verilator
FLAGS      = --timing --assert
TOP        = tb_levinson_durbin
RTL_TOP    = levinson_durbin
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* include/ld_ref_model.svh */
// Levinson-Durbin reference model
// order-10 recursion in Q31.16 with truncating products, divide, clamp and energy rules
`ifndef LD_REF_MODEL_SVH
`define LD_REF_MODEL_SVH

localparam logic signed [`FIX_W-1:0] REF_ONE =
	{{(`FIX_W-`FIX_FRAC-1){1'b0}}, 1'b1, {`FIX_FRAC{1'b0}}};

// autocorrelation in, expected a0..a10 out
logic signed [`FIX_W-1:0] ref_r [0:`LPC_ORDER];
logic signed [`FIX_W-1:0] ref_a [0:`LPC_ORDER];

// full product, arithmetic shift right by the fraction bits
function automatic logic signed [`FIX_W-1:0] q_mul(input logic signed [`FIX_W-1:0] a,
	input logic signed [`FIX_W-1:0] b);
	logic signed [2*`FIX_W-1:0] wide_a;
	logic signed [2*`FIX_W-1:0] wide_b;
	logic signed [2*`FIX_W-1:0] shifted;
	wide_a = a;
	wide_b = b;
	shifted = (wide_a * wide_b) >>> `FIX_FRAC;
	return shifted[`FIX_W-1:0];
endfunction

// magnitudes divided and truncated, sign applied last, zero for a zero divisor
function automatic logic signed [`FIX_W-1:0] q_div(input logic signed [`FIX_W-1:0] num,
	input logic signed [`FIX_W-1:0] den);
	logic [`FIX_W-1:0] num_abs;
	logic [`FIX_W-1:0] den_abs;
	logic [`FIX_W+`FIX_FRAC-1:0] quot;
	logic signed [`FIX_W-1:0] low;
	if (den == '0)
		return '0;
	num_abs = num[`FIX_W-1] ? -num : num;
	den_abs = den[`FIX_W-1] ? -den : den;
	quot = {num_abs, {`FIX_FRAC{1'b0}}} / {{`FIX_FRAC{1'b0}}, den_abs};
	low = quot[`FIX_W-1:0];
	return (num[`FIX_W-1] != den[`FIX_W-1]) ? -low : low;
endfunction

task automatic run_ref_model();
	logic signed [`FIX_W-1:0] e;
	logic signed [`FIX_W-1:0] k;
	logic signed [`FIX_W-1:0] acc;
	logic signed [`FIX_W-1:0] prev [0:`LPC_ORDER];
	ref_a[0] = REF_ONE;
	for (int j = 1; j <= `LPC_ORDER; j++)
		ref_a[j] = '0;
	e = ref_r[0];
	for (int i = 1; i <= `LPC_ORDER; i++)
	begin
		acc = '0;
		for (int j = 1; j < i; j++)
			acc = acc + q_mul(ref_a[j], ref_r[i-j]);
		k = q_div(-(ref_r[i] + acc), e);
		// reflection outside the unit range is dropped
		if (k > REF_ONE || k < -REF_ONE)
			k = '0;
		prev = ref_a;
		for (int j = 1; j < i; j++)
			ref_a[j] = prev[j] + q_mul(k, prev[i-j]);
		ref_a[i] = k;
		e = q_mul(e, REF_ONE - q_mul(k, k));
	end
endtask

`endif

/* bench/tb_levinson_durbin.sv */
// Levinson-Durbin testbench
// directed runs checked against the reference model, coefficient by coefficient
`timescale 1ns/1ps
`default_nettype none

`include "lpc_params.svh"

module tb_levinson_durbin;

	localparam int N_RUNS = 10;
	localparam int RUN_CYCLES = `LPC_ORDER * (`FIX_W + `FIX_FRAC + 20) + 40;
	localparam int N_SAMPLES = 24;

	logic clk;
	logic rst;
	logic startld;
	lpc_pkg::fix_t r [0:`LPC_ORDER];
	logic lpc_valid;
	lpc_pkg::order_t addr_ld;
	lpc_pkg::lpc_out_t in_lpc;
	logic doneld;

	int errors = 0;
	int checks = 0;
	logic [31:0] rng_state = 32'd5377;

	`include "ld_ref_model.svh"

	levinson_durbin i_dut (
		.clk       (clk),
		.rst       (rst),
		.startld   (startld),
		.r         (r),
		.lpc_valid (lpc_valid),
		.addr_ld   (addr_ld),
		.in_lpc    (in_lpc),
		.doneld    (doneld)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] xorshift32();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	task automatic check_equal(input string name, input logic [`FIX_W-1:0] got,
		input logic [`FIX_W-1:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("error at %0t: %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	task automatic report_and_finish();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	// autocorrelation of a short random sequence, samples within +-0.5
	task automatic make_autocorr_inputs();
		longint x [0:N_SAMPLES-1];
		longint acc;
		for (int n = 0; n < N_SAMPLES; n++)
			x[n] = longint'(xorshift32() & 32'hffff) - 64'sd32768;
		for (int m = 0; m <= `LPC_ORDER; m++)
		begin
			acc = 0;
			for (int n = 0; n + m < N_SAMPLES; n++)
				acc = acc + x[n] * x[n+m];
			ref_r[m] = `FIX_W'(acc >>> `FIX_FRAC);
		end
	endtask

	// drive ref_r onto the DUT and work out the expected stream
	task automatic apply_inputs();
		@(posedge clk);
		for (int m = 0; m <= `LPC_ORDER; m++)
			r[m] <= ref_r[m];
		run_ref_model();
	endtask

	task automatic pulse_start();
		@(posedge clk);
		startld <= 1'b1;
		@(posedge clk);
		startld <= 1'b0;
	endtask

	// waits for the first valid, then 11 coefficients and one doneld
	task automatic check_stream();
		int waited;
		logic [`FIX_W-1:0] got_w;
		logic [`FIX_W-1:0] exp_w;
		waited = 0;
		@(negedge clk);
		while (!lpc_valid && waited < RUN_CYCLES)
		begin
			check_equal("doneld", `FIX_W'(doneld), '0);
			@(negedge clk);
			waited++;
		end
		checks++;
		assert (lpc_valid)
		else
		begin
			errors++;
			$display("no coefficient stream within %0d cycles of the start", RUN_CYCLES);
		end
		if (!lpc_valid)
			return;
		for (int a = 0; a <= `LPC_ORDER; a++)
		begin
			got_w = {{(`FIX_W-`LPC_OUT_W){1'b0}}, in_lpc};
			exp_w = {{(`FIX_W-`LPC_OUT_W){1'b0}}, ref_a[a][`LPC_OUT_W-1:0]};
			check_equal("lpc_valid", `FIX_W'(lpc_valid), `FIX_W'(1));
			check_equal("addr_ld", `FIX_W'(addr_ld), `FIX_W'(a));
			check_equal("in_lpc", got_w, exp_w);
			check_equal("doneld", `FIX_W'(doneld), '0);
			@(negedge clk);
		end
		check_equal("lpc_valid", `FIX_W'(lpc_valid), '0);
		check_equal("doneld", `FIX_W'(doneld), `FIX_W'(1));
		@(negedge clk);
		check_equal("doneld", `FIX_W'(doneld), '0);
	endtask

	task automatic run_and_check();
		apply_inputs();
		pulse_start();
		check_stream();
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_reset();
		repeat (10)
		begin
			@(negedge clk);
			check_equal("lpc_valid", `FIX_W'(lpc_valid), '0);
			check_equal("doneld", `FIX_W'(doneld), '0);
		end
		@(posedge clk);
		rst <= 1'b1;
		repeat (20)
		begin
			@(negedge clk);
			check_equal("lpc_valid", `FIX_W'(lpc_valid), '0);
			check_equal("doneld", `FIX_W'(doneld), '0);
		end
	endtask

	task automatic test_white();
		for (int m = 0; m <= `LPC_ORDER; m++)
			ref_r[m] = '0;
		ref_r[0] = REF_ONE;
		run_and_check();
	endtask

	// r_n = 0.5^n gives a single pole at 0.5
	task automatic test_first_order();
		for (int m = 0; m <= `LPC_ORDER; m++)
			ref_r[m] = REF_ONE >>> m;
		apply_inputs();
		check_equal("model a1", ref_a[1], -(REF_ONE >>> 1));
		for (int m = 2; m <= `LPC_ORDER; m++)
			check_equal("model a", ref_a[m], '0);
		pulse_start();
		check_stream();
	endtask

	task automatic test_random();
		repeat (4)
		begin
			make_autocorr_inputs();
			run_and_check();
		end
	endtask

	// r1 = 1.5 * r0 pushes k past one at order 1
	// nothing beyond r1, so later orders leave a1 alone
	task automatic test_clamp();
		for (int m = 0; m <= `LPC_ORDER; m++)
			ref_r[m] = '0;
		ref_r[0] = REF_ONE;
		ref_r[1] = REF_ONE + (REF_ONE >>> 1);
		apply_inputs();
		check_equal("model a1", ref_a[1], '0);
		pulse_start();
		check_stream();
	endtask

	// startld held high: two back-to-back runs, dropped once the second one streams
	task automatic test_start_held();
		make_autocorr_inputs();
		apply_inputs();
		@(posedge clk);
		startld <= 1'b1;
		check_stream();
		fork
			check_stream();
			begin
				do
					@(negedge clk);
				while (!lpc_valid);
				@(posedge clk);
				startld <= 1'b0;
			end
		join
	endtask

	// ----------------------------------------------------------------------
	// main sequence and watchdog
	// ----------------------------------------------------------------------
	initial
	begin
		rst = 1'b0;
		startld = 1'b0;
		for (int m = 0; m <= `LPC_ORDER; m++)
			r[m] = '0;
		test_reset();
		test_white();
		test_first_order();
		test_random();
		test_clamp();
		test_start_held();
		repeat (5) @(posedge clk);
		report_and_finish();
	end

	initial
	begin
		repeat (N_RUNS * RUN_CYCLES) @(posedge clk);
		errors++;
		$display("timeout, the tests did not finish within %0d cycles", N_RUNS * RUN_CYCLES);
		report_and_finish();
	end

endmodule

`default_nettype wire

/* verilog/levinson_durbin.sv */
// Levinson-Durbin top level
// r0..r10 in, order-10 predictor coefficients streamed out on addr_ld and in_lpc
`timescale 1ns/1ps
`default_nettype none

`include "lpc_params.svh"

module levinson_durbin (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          startld,
	input  wire lpc_pkg::fix_t r [0:`LPC_ORDER],
	output logic               lpc_valid,
	output lpc_pkg::order_t    addr_ld,
	output lpc_pkg::lpc_out_t  in_lpc,
	output logic               doneld
);

	logic div_start;
	logic div_done;
	lpc_pkg::fix_t div_num;
	lpc_pkg::fix_t div_den;
	lpc_pkg::fix_t div_quot;
	logic clear;
	logic step;
	logic finish;
	logic drain_busy;
	lpc_pkg::order_t order_i;
	lpc_pkg::fix_t k;
	lpc_pkg::fix_t partner [1:`LPC_ORDER];
	lpc_pkg::fix_t coef [1:`LPC_ORDER];

	ld_sequencer i_seq (
		.clk        (clk),
		.rst        (rst),
		.startld    (startld),
		.drain_busy (drain_busy),
		.r          (r),
		.coef       (coef),
		.div_quot   (div_quot),
		.div_done   (div_done),
		.div_start  (div_start),
		.div_num    (div_num),
		.div_den    (div_den),
		.clear      (clear),
		.step       (step),
		.order_i    (order_i),
		.k          (k),
		.partner    (partner),
		.finish     (finish)
	);

	fix_divider i_div (
		.clk       (clk),
		.rst       (rst),
		.div_start (div_start),
		.div_num   (div_num),
		.div_den   (div_den),
		.div_quot  (div_quot),
		.div_done  (div_done)
	);

	// -----------------------------------------------------------------
	// coefficient lanes a1..a10, all updating on the same step
	// -----------------------------------------------------------------
	for (genvar l = 1; l <= `LPC_ORDER; l++)
	begin : g_lane
		coef_lane #(.lane(l)) i_lane (
			.clk     (clk),
			.rst     (rst),
			.clear   (clear),
			.step    (step),
			.order_i (order_i),
			.k       (k),
			.partner (partner[l]),
			.coef    (coef[l])
		);
	end

	lpc_drain i_drain (
		.clk        (clk),
		.rst        (rst),
		.finish     (finish),
		.coef       (coef),
		.lpc_valid  (lpc_valid),
		.addr_ld    (addr_ld),
		.in_lpc     (in_lpc),
		.doneld     (doneld),
		.drain_busy (drain_busy)
	);

endmodule

`default_nettype wire

/* verilog/lpc_drain.sv */
// Coefficient output stream
// sends a0 = 1.0 then a1..a10, one per cycle, and pulses doneld after the last
`timescale 1ns/1ps
`default_nettype none

`include "lpc_params.svh"

module lpc_drain (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          finish,
	input  wire lpc_pkg::fix_t coef [1:`LPC_ORDER],
	output logic               lpc_valid,
	output lpc_pkg::order_t    addr_ld,
	output lpc_pkg::lpc_out_t  in_lpc,
	output logic               doneld,
	output logic               drain_busy
);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			lpc_valid <= 1'b0;
			addr_ld <= '0;
			doneld <= 1'b0;
		end
		else
		begin
			doneld <= 1'b0;
			if (finish)
			begin
				lpc_valid <= 1'b1;
				addr_ld <= '0;
			end
			else if (lpc_valid)
			begin
				if (addr_ld == `LPC_ORDER)
				begin
					lpc_valid <= 1'b0;
					doneld <= 1'b1;
				end
				else
				begin
					addr_ld <= addr_ld + 1'b1;
				end
			end
		end
	end

	// a0 is fixed at one
	always_comb
	begin
		if (addr_ld == '0)
			in_lpc = lpc_pkg::FIX_ONE[`LPC_OUT_W-1:0];
		else
			in_lpc = coef[addr_ld][`LPC_OUT_W-1:0];
	end

	// holds off a new run until doneld has gone out
	assign drain_busy = lpc_valid || doneld;

	a_addr_range: assert property (@(posedge clk) disable iff (!rst)
		lpc_valid |-> (addr_ld <= `LPC_ORDER));

endmodule

`default_nettype wire

/* verilog/coef_lane.sv */
// Predictor coefficient lane
// holds a_j and applies the per-order update a_j += k * a_(i-j)
`timescale 1ns/1ps
`default_nettype none

`include "lpc_params.svh"

module coef_lane #(
	parameter int lane = 1
) (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            clear,
	input  wire logic            step,
	input  wire lpc_pkg::order_t order_i,
	input  wire lpc_pkg::fix_t   k,
	input  wire lpc_pkg::fix_t   partner,
	output lpc_pkg::fix_t        coef
);

	localparam lpc_pkg::order_t IDX = lpc_pkg::order_t'(lane);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			coef <= '0;
		else if (clear)
			coef <= '0;
		else if (step)
		begin
			if (IDX < order_i)
				coef <= coef + lpc_pkg::fix_mul(k, partner);
			// newest coefficient of this order is k itself
			else if (IDX == order_i)
				coef <= k;
		end
	end

	// orders run from 1 up
	a_step_order: assert property (@(posedge clk) disable iff (!rst)
		step |-> (order_i != '0) && (order_i <= `LPC_ORDER));

endmodule

`default_nettype wire

/* verilog/ld_sequencer.sv */
// Levinson-Durbin controller
// running sum, divide, clamp and energy update per order, with one shared multiplier
`timescale 1ns/1ps
`default_nettype none

`include "lpc_params.svh"

module ld_sequencer (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          startld,
	input  wire logic          drain_busy,
	input  wire lpc_pkg::fix_t r [0:`LPC_ORDER],
	input  wire lpc_pkg::fix_t coef [1:`LPC_ORDER],
	input  wire lpc_pkg::fix_t div_quot,
	input  wire logic          div_done,
	output logic               div_start,
	output lpc_pkg::fix_t      div_num,
	output lpc_pkg::fix_t      div_den,
	output logic               clear,
	output logic               step,
	output lpc_pkg::order_t    order_i,
	output lpc_pkg::fix_t      k,
	output lpc_pkg::fix_t      partner [1:`LPC_ORDER],
	output logic               finish
);

	lpc_pkg::ld_state_e state;
	lpc_pkg::order_t j;
	lpc_pkg::fix_t sum;
	lpc_pkg::fix_t e;
	lpc_pkg::fix_t e_scale;
	lpc_pkg::fix_t mul_a;
	lpc_pkg::fix_t mul_b;
	lpc_pkg::fix_t prod;

	// -----------------------------------------------------------------
	// shared multiplier operand select
	// -----------------------------------------------------------------
	always_comb
	begin
		mul_a = k;
		mul_b = k;
		case (state)
			lpc_pkg::SUM:
			begin
				mul_a = coef[j];
				mul_b = r[order_i - j];
			end
			lpc_pkg::ENERGY:
			begin
				mul_a = e;
				mul_b = e_scale;
			end
			default:
			begin
			end
		endcase
		prod = lpc_pkg::fix_mul(mul_a, mul_b);
	end

	// lane j pairs with coef[i-j] for the symmetric update
	always_comb
	begin
		for (int l = 1; l <= `LPC_ORDER; l++)
		begin
			if (lpc_pkg::order_t'(l) < order_i)
				partner[l] = coef[order_i - lpc_pkg::order_t'(l)];
			else
				partner[l] = '0;
		end
	end

	// -----------------------------------------------------------------
	// state machine
	// -----------------------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= lpc_pkg::IDLE;
			order_i <= '0;
			j <= '0;
			div_start <= 1'b0;
			clear <= 1'b0;
			step <= 1'b0;
			finish <= 1'b0;
		end
		else
		begin
			div_start <= 1'b0;
			clear <= 1'b0;
			step <= 1'b0;
			finish <= 1'b0;
			case (state)
				lpc_pkg::IDLE:
				begin
					if (startld && !drain_busy)
					begin
						clear <= 1'b1;
						order_i <= 1;
						j <= 1;
						state <= lpc_pkg::SUM;
					end
				end
				lpc_pkg::SUM:
				begin
					if (j < order_i)
					begin
						j <= j + 1'b1;
					end
					else
					begin
						div_start <= 1'b1;
						state <= lpc_pkg::DIVIDE;
					end
				end
				lpc_pkg::DIVIDE:
				begin
					if (div_done)
						state <= lpc_pkg::CLAMP;
				end
				lpc_pkg::CLAMP:
				begin
					step <= 1'b1;
					state <= lpc_pkg::UPDATE;
				end
				lpc_pkg::UPDATE:
				begin
					state <= lpc_pkg::ENERGY;
				end
				lpc_pkg::ENERGY:
				begin
					if (order_i == `LPC_ORDER)
					begin
						finish <= 1'b1;
						state <= lpc_pkg::FINISH;
					end
					else
					begin
						order_i <= order_i + 1'b1;
						j <= 1;
						state <= lpc_pkg::SUM;
					end
				end
				default:
				begin
					state <= lpc_pkg::IDLE;
				end
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge clk)
	begin
		case (state)
			lpc_pkg::IDLE:
			begin
				e <= r[0];
				sum <= '0;
			end
			lpc_pkg::SUM:
			begin
				if (j < order_i)
				begin
					sum <= sum + prod;
				end
				else
				begin
					div_num <= -(r[order_i] + sum);
					div_den <= e;
				end
			end
			lpc_pkg::DIVIDE:
			begin
				if (div_done)
					k <= div_quot;
			end
			lpc_pkg::CLAMP:
			begin
				// unstable reflection, drop it
				if (k > lpc_pkg::FIX_ONE || k < -lpc_pkg::FIX_ONE)
					k <= '0;
			end
			lpc_pkg::UPDATE:
			begin
				e_scale <= lpc_pkg::FIX_ONE - prod;
			end
			lpc_pkg::ENERGY:
			begin
				e <= prod;
				sum <= '0;
			end
			default:
			begin
			end
		endcase
	end

	// the drain must never see a lane still updating
	a_step_finish: assert property (@(posedge clk) disable iff (!rst)
		!(step && finish));

endmodule

`default_nettype wire

/* verilog/fix_divider.sv */
// Reflection coefficient divider
// restoring division of |num|*2^16 by |den|, one quotient bit per cycle, sign applied last
`timescale 1ns/1ps
`default_nettype none

`include "lpc_params.svh"

module fix_divider (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          div_start,
	input  wire lpc_pkg::fix_t div_num,
	input  wire lpc_pkg::fix_t div_den,
	output lpc_pkg::fix_t      div_quot,
	output logic               div_done
);

	// one step per dividend bit
	localparam logic [6:0] LAST = 7'(`FIX_W + `FIX_FRAC - 1);

	logic busy;
	logic [6:0] cnt;
	logic neg;
	logic den_zero;
	logic [`FIX_W-1:0] num_mag;
	logic [`FIX_W-1:0] den_mag;
	logic [`FIX_W:0] rem;
	logic [`FIX_W:0] rem_sh;
	logic [`FIX_W:0] trial;
	logic [`FIX_W:0] rem_nx;
	logic [`FIX_W+`FIX_FRAC-1:0] quo;
	logic [`FIX_W+`FIX_FRAC-1:0] quo_nx;
	logic fits;

	assign num_mag = div_num[`FIX_W-1] ? -div_num : div_num;

	// -----------------------------------------------------------------
	// one restoring step
	// -----------------------------------------------------------------
	always_comb
	begin
		rem_sh = {rem[`FIX_W-1:0], quo[`FIX_W+`FIX_FRAC-1]};
		trial = rem_sh - {1'b0, den_mag};
		fits = !trial[`FIX_W];
		rem_nx = fits ? trial : rem_sh;
		quo_nx = {quo[`FIX_W+`FIX_FRAC-2:0], fits};
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			cnt <= '0;
			div_done <= 1'b0;
		end
		else
		begin
			div_done <= 1'b0;
			if (div_start)
			begin
				busy <= 1'b1;
				cnt <= '0;
			end
			else if (busy)
			begin
				if (cnt == LAST)
				begin
					busy <= 1'b0;
					div_done <= 1'b1;
				end
				else
				begin
					cnt <= cnt + 7'd1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (div_start)
		begin
			rem <= '0;
			quo <= {num_mag, `FIX_FRAC'(0)};
			den_mag <= div_den[`FIX_W-1] ? -div_den : div_den;
			neg <= div_num[`FIX_W-1] ^ div_den[`FIX_W-1];
			den_zero <= (div_den == '0);
		end
		else if (busy)
		begin
			rem <= rem_nx;
			quo <= quo_nx;
			if (cnt == LAST)
			begin
				// divide by zero gives zero
				if (den_zero)
					div_quot <= '0;
				else if (neg)
					div_quot <= -lpc_pkg::fix_t'(quo_nx[`FIX_W-1:0]);
				else
					div_quot <= lpc_pkg::fix_t'(quo_nx[`FIX_W-1:0]);
			end
		end
	end

	// the sequencer waits for div_done before the next order's divide
	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst)
		div_start |-> !busy);

endmodule

`default_nettype wire

/* verilog/lpc_pkg.sv */
// LPC shared types
// fixed-point words, order index, sequencer states and the Q-format product
`default_nettype none

`include "lpc_params.svh"

package lpc_pkg;

	typedef logic signed [`FIX_W-1:0] fix_t;
	typedef logic signed [`LPC_OUT_W-1:0] lpc_out_t;
	typedef logic [$clog2(`LPC_ORDER+1)-1:0] order_t;

	typedef enum logic [2:0] {IDLE, SUM, DIVIDE, CLAMP, UPDATE, ENERGY, FINISH} ld_state_e;

	// 1.0 in Q31.16
	localparam fix_t FIX_ONE = fix_t'(1 << `FIX_FRAC);

	// full signed product, arithmetic shift by the fraction bits, keep FIX_W bits
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [2*`FIX_W-1:0] full;
		full = (2*`FIX_W)'(a) * (2*`FIX_W)'(b);
		return full[`FIX_W+`FIX_FRAC-1:`FIX_FRAC];
	endfunction

endpackage

`default_nettype wire

/* include/lpc_params.svh */
// LPC recursion sizing
// prediction order, fixed-point widths and fraction bits
`ifndef LPC_PARAMS_SVH
`define LPC_PARAMS_SVH

// prediction order, so r0 to r10 in and a0 to a10 out
`define LPC_ORDER 10

// internal word, two's complement Q31.16
`define FIX_W 48

// fraction bits of the internal word
`define FIX_FRAC 16

// streamed coefficient width, low bits of the internal word
`define LPC_OUT_W 32

`endif
